//--- core_top.f
+incdir+rtl
rtl/core_pkg.sv
rtl/stage_control.sv
rtl/instruction_fetcher.sv
rtl/instruction_decoder.sv
rtl/register_file.sv
rtl/instruction_executor.sv
rtl/core_top.sv
test/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_TEXT="FAIL: see errors above"

verilator --binary --timing --assert -j 0 \
  --top-module core_tb \
  -Mdir "$BUILD_DIR" -o core_sim \
  -f core_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/core_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
  exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- test/core_tb.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module core_tb;
  import core_pkg::*;

  localparam int  RESET_CYCLES   = 8;
  localparam int  NUM_RETIRES    = 300;
  localparam int  TIMEOUT_CYCLES = NUM_RETIRES * 9 + 100;
  localparam pc_t ENTRY_PC       = 64'h0000_0000_8000_0100;

  logic      clk;
  logic      reset;
  pc_t       entry;
  pc_t       ibus_adr;
  logic      ibus_cyc;
  logic      ibus_stb;
  instr_t    ibus_rdata;
  logic      ibus_ack;
  logic      retire_valid;
  pc_t       retire_pc;
  reg_addr_t retire_rd;
  xlen_t     retire_data;

  // Program image, ISA model state and bookkeeping
  instr_t      program_mem [64];
  xlen_t       model_regs [32];
  pc_t         model_pc;
  logic [31:0] lcg_state;
  logic [1:0]  waits;
  logic        req_active;
  logic        first_fetch;
  logic        adr_wait;
  pc_t         held_adr;
  int          since_ack;
  int          cycle_count;
  int          retire_count;
  int          errors;

  core_top i_core_top (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .ibus_adr     (ibus_adr),
    .ibus_cyc     (ibus_cyc),
    .ibus_stb     (ibus_stb),
    .ibus_rdata   (ibus_rdata),
    .ibus_ack     (ibus_ack),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    errors++;
    $display("[FAIL] %0t %s: expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Mostly ALU forms on x0..x7, some LUI and JAL, one in sixteen unsupported
  task automatic build_program();
    logic [15:0] r;
    logic [15:0] s;
    reg_addr_t   rd_f;
    reg_addr_t   rs1_f;
    reg_addr_t   rs2_f;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [20:0] joff;
    int          off;
    for (int i = 0; i < 64; i++) begin
      r     = next_random();
      s     = next_random();
      rd_f  = {2'b00, r[6:4]};
      rs1_f = {2'b00, r[9:7]};
      rs2_f = {2'b00, r[12:10]};
      case (r[3:0])
        4'd0: program_mem[i] = {s, r[15:7], 7'b0000011};
        4'd6, 4'd7, 4'd8, 4'd9, 4'd10: begin
          case (s[2:0])
            3'd0, 3'd1: {f7, f3} = {7'b0000000, 3'b000};
            3'd2, 3'd3: {f7, f3} = {7'b0100000, 3'b000};
            3'd4:       {f7, f3} = {7'b0000000, 3'b100};
            3'd5:       {f7, f3} = {7'b0000000, 3'b110};
            default:    {f7, f3} = {7'b0000000, 3'b111};
          endcase
          program_mem[i] = {f7, rs2_f, rs1_f, f3, rd_f, `CORE_OPC_OP};
        end
        4'd11, 4'd12: program_mem[i] = {s, r[15:12], rd_f, `CORE_OPC_LUI};
        4'd13: begin
          // Forward 1..4 words, or -63..-60 which wraps forward in the 64-word memory
          off  = s[2] ? (int'(s[1:0]) - 63) * 4 : (int'(s[1:0]) + 1) * 4;
          joff = off[20:0];
          program_mem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd_f,
                            `CORE_OPC_JAL};
        end
        default: begin
          case (s[13:12])
            2'd0:    f3 = 3'b000;
            2'd1:    f3 = 3'b100;
            2'd2:    f3 = 3'b110;
            default: f3 = 3'b111;
          endcase
          program_mem[i] = {s[11:0], rs1_f, f3, rd_f, `CORE_OPC_OP_IMM};
        end
      endcase
    end
  endtask

  // Executes the instruction at model_pc and compares it with the retire port
  task automatic retire_model();
    instr_t    w;
    xlen_t     a;
    xlen_t     b;
    xlen_t     v;
    pc_t       next_pc;
    logic      writes;
    reg_addr_t exp_rd;
    w       = program_mem[model_pc[7:2]];
    a       = model_regs[w[19:15]];
    b       = model_regs[w[24:20]];
    v       = '0;
    writes  = 1'b1;
    next_pc = model_pc + 64'd4;
    case (w[6:0])
      `CORE_OPC_OP_IMM: begin
        b = {{52{w[31]}}, w[31:20]};
        case (w[14:12])
          3'b000:  v = a + b;
          3'b100:  v = a ^ b;
          3'b110:  v = a | b;
          3'b111:  v = a & b;
          default: writes = 1'b0;
        endcase
      end
      `CORE_OPC_OP: begin
        case ({w[31:25], w[14:12]})
          10'b0000000_000: v = a + b;
          10'b0100000_000: v = a - b;
          10'b0000000_100: v = a ^ b;
          10'b0000000_110: v = a | b;
          10'b0000000_111: v = a & b;
          default:         writes = 1'b0;
        endcase
      end
      `CORE_OPC_LUI: v = {{32{w[31]}}, w[31:12], 12'h000};
      `CORE_OPC_JAL: begin
        v       = model_pc + 64'd4;
        next_pc = model_pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      default: writes = 1'b0;
    endcase
    exp_rd = writes ? w[11:7] : 5'd0;
    assert (retire_pc == model_pc) else report_mismatch("retire_pc", model_pc, retire_pc);
    assert (retire_rd == exp_rd)
      else report_mismatch("retire_rd", 64'(exp_rd), 64'(retire_rd));
    if (exp_rd != 5'd0) begin
      assert (retire_data == v) else report_mismatch("retire_data", v, retire_data);
      model_regs[exp_rd] = v;
    end
    model_pc = next_pc;
    retire_count++;
  endtask

  // Outputs are sampled at the falling edge, ibus_ack still holds last cycle's value
  task automatic check_cycle();
    logic expect_retire;
    if (reset) begin
      assert (!ibus_cyc && !ibus_stb && !retire_valid)
        else report_problem("bus strobes or retire_valid high during reset");
    end else begin
      assert (ibus_cyc == ibus_stb)
        else report_mismatch("ibus_cyc", 64'(ibus_stb), 64'(ibus_cyc));
      if (adr_wait) begin
        assert (ibus_adr == held_adr) else report_mismatch("ibus_adr", held_adr, ibus_adr);
      end
      if (ibus_ack) begin
        assert (!ibus_stb) else report_problem("ibus_stb still high after the ack cycle");
        since_ack = 1;
      end else if (since_ack > 0) begin
        since_ack++;
      end
      expect_retire = (since_ack == 3);
      assert (retire_valid == expect_retire)
        else report_mismatch("retire_valid", 64'(expect_retire), 64'(retire_valid));
      if (since_ack >= 3) begin
        since_ack = 0;
      end
      if (ibus_stb && !req_active) begin
        if (first_fetch) begin
          assert (ibus_adr == entry) else report_mismatch("ibus_adr", entry, ibus_adr);
          first_fetch = 1'b0;
        end
        assert (ibus_adr == model_pc) else report_mismatch("ibus_adr", model_pc, ibus_adr);
      end
      if (retire_valid) begin
        retire_model();
      end
    end
  endtask

  // Wishbone slave with 0 to 3 wait cycles per request
  task automatic drive_memory();
    logic [15:0] r;
    if (ibus_ack) begin
      ibus_ack   = 1'b0;
      req_active = 1'b0;
    end else if (ibus_stb) begin
      if (!req_active) begin
        r          = next_random();
        req_active = 1'b1;
        waits      = r[1:0];
      end
      if (waits == 2'd0) begin
        ibus_ack   = 1'b1;
        ibus_rdata = program_mem[ibus_adr[7:2]];
      end else begin
        waits = waits - 2'd1;
      end
    end
    adr_wait = ibus_stb && !ibus_ack;
    held_adr = ibus_adr;
  endtask

  initial begin
    reset        = 1'b1;
    entry        = ENTRY_PC;
    ibus_rdata   = '0;
    ibus_ack     = 1'b0;
    lcg_state    = 32'd40398;
    model_pc     = ENTRY_PC;
    waits        = 2'd0;
    req_active   = 1'b0;
    first_fetch  = 1'b1;
    adr_wait     = 1'b0;
    held_adr     = '0;
    since_ack    = 0;
    cycle_count  = 0;
    retire_count = 0;
    errors       = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    build_program();
    while (retire_count < NUM_RETIRES && cycle_count < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycle_count++;
      check_cycle();
      drive_memory();
      if (cycle_count == RESET_CYCLES) begin
        reset = 1'b0;
      end
    end
    if (retire_count < NUM_RETIRES) begin
      $display("Timeout: only %0d of %0d instructions retired in %0d cycles",
               retire_count, NUM_RETIRES, cycle_count);
      errors++;
    end
    $display("Errors: %0d, retired: %0d, cycles: %0d", errors, retire_count, cycle_count);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- rtl/core_top.sv
`timescale 1ns/100ps

module core_top (
  input  logic                clk,
  input  logic                reset,
  input  core_pkg::pc_t       entry,
  output core_pkg::pc_t       ibus_adr,
  output logic                ibus_cyc,
  output logic                ibus_stb,
  input  core_pkg::instr_t    ibus_rdata,
  input  logic                ibus_ack,
  output logic                retire_valid,
  output core_pkg::pc_t       retire_pc,
  output core_pkg::reg_addr_t retire_rd,
  output core_pkg::xlen_t     retire_data
);
  import core_pkg::*;

  // Sequencing strobes
  logic fetch_start;
  logic fetch_done;
  logic execute_en;
  logic write_en;
  logic pc_update;

  // Fetch outputs
  instr_t instr;
  pc_t    pc;

  // Decoded fields
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  xlen_t     imm;
  alu_op_t   alu_op;
  logic      use_imm;
  logic      is_jump;

  // Operands and results
  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t result;
  pc_t   jump_target;

  stage_control i_stage_control (
    .clk          (clk),
    .reset        (reset),
    .fetch_done   (fetch_done),
    .fetch_start  (fetch_start),
    .execute_en   (execute_en),
    .write_en     (write_en),
    .pc_update    (pc_update),
    .retire_valid (retire_valid)
  );

  instruction_fetcher i_instruction_fetcher (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .fetch_start (fetch_start),
    .pc_update   (pc_update),
    .is_jump     (is_jump),
    .jump_target (jump_target),
    .ibus_adr    (ibus_adr),
    .ibus_cyc    (ibus_cyc),
    .ibus_stb    (ibus_stb),
    .ibus_rdata  (ibus_rdata),
    .ibus_ack    (ibus_ack),
    .instr       (instr),
    .pc          (pc),
    .fetch_done  (fetch_done)
  );

  instruction_decoder i_instruction_decoder (
    .instr   (instr),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .imm     (imm),
    .alu_op  (alu_op),
    .use_imm (use_imm),
    .is_jump (is_jump)
  );

  register_file i_register_file (
    .clk      (clk),
    .reset    (reset),
    .write_en (write_en),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .result   (result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  instruction_executor i_instruction_executor (
    .clk         (clk),
    .reset       (reset),
    .execute_en  (execute_en),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .use_imm     (use_imm),
    .alu_op      (alu_op),
    .result      (result),
    .jump_target (jump_target)
  );

  // Retire port taps the write-back values
  assign retire_pc   = pc;
  assign retire_rd   = rd;
  assign retire_data = result;

endmodule

//--- rtl/instruction_executor.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module instruction_executor (
  input  logic              clk,
  input  logic              reset,
  input  logic              execute_en,
  input  core_pkg::pc_t     pc,
  input  core_pkg::xlen_t   rs1_data,
  input  core_pkg::xlen_t   rs2_data,
  input  core_pkg::xlen_t   imm,
  input  logic              use_imm,
  input  core_pkg::alu_op_t alu_op,
  output core_pkg::xlen_t   result,
  output core_pkg::pc_t     jump_target
);
  import core_pkg::*;

  xlen_t operand_b;
  xlen_t alu_out;

  // Immediate forms replace rs2
  assign operand_b = use_imm ? imm : rs2_data;

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_out = rs1_data + operand_b;
      ALU_SUB:    alu_out = rs1_data - operand_b;
      ALU_XOR:    alu_out = rs1_data ^ operand_b;
      ALU_OR:     alu_out = rs1_data | operand_b;
      ALU_AND:    alu_out = rs1_data & operand_b;
      ALU_PASS_B: alu_out = operand_b;
      // Return address for JAL
      ALU_LINK:   alu_out = pc + pc_t'(`CORE_PC_STEP);
      default:    alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (execute_en) begin
      result <= alu_out;
    end
  end

  // PC-relative target, only used when the decoder flags a jump
  assign jump_target = pc + imm;

endmodule

//--- rtl/register_file.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module register_file (
  input  logic                clk,
  input  logic                reset,
  input  logic                write_en,
  input  core_pkg::reg_addr_t rd,
  input  core_pkg::reg_addr_t rs1,
  input  core_pkg::reg_addr_t rs2,
  input  core_pkg::xlen_t     result,
  output core_pkg::xlen_t     rs1_data,
  output core_pkg::xlen_t     rs2_data
);
  import core_pkg::*;

  localparam int NUM_REGS = 1 << `CORE_REG_ADDR_W;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (rd != '0)) begin
      regs[rd] <= result;
    end
  end

  // x0 is hardwired zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- rtl/instruction_decoder.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module instruction_decoder (
  input  core_pkg::instr_t    instr,
  output core_pkg::reg_addr_t rs1,
  output core_pkg::reg_addr_t rs2,
  output core_pkg::reg_addr_t rd,
  output core_pkg::xlen_t     imm,
  output core_pkg::alu_op_t   alu_op,
  output logic                use_imm,
  output logic                is_jump
);
  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       supported;

  // Fixed RV field positions
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // Sign-extended immediates
  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Unsupported encodings retire without a register write
  assign rd = supported ? instr[11:7] : '0;

  always_comb begin
    alu_op    = ALU_ADD;
    imm       = imm_i;
    use_imm   = 1'b0;
    is_jump   = 1'b0;
    supported = 1'b0;
    case (opcode)
      `CORE_OPC_OP_IMM: begin
        use_imm   = 1'b1;
        supported = 1'b1;
        case (funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: supported = 1'b0;
        endcase
      end
      `CORE_OPC_OP: begin
        supported = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = ALU_SUB;
          {7'b0000000, 3'b100}: alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: alu_op = ALU_OR;
          {7'b0000000, 3'b111}: alu_op = ALU_AND;
          default:              supported = 1'b0;
        endcase
      end
      `CORE_OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        imm       = imm_u;
        use_imm   = 1'b1;
        supported = 1'b1;
      end
      `CORE_OPC_JAL: begin
        alu_op    = ALU_LINK;
        imm       = imm_j;
        is_jump   = 1'b1;
        supported = 1'b1;
      end
      default: supported = 1'b0;
    endcase
  end

endmodule

//--- rtl/instruction_fetcher.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module instruction_fetcher (
  input  logic             clk,
  input  logic             reset,
  input  core_pkg::pc_t    entry,
  input  logic             fetch_start,
  input  logic             pc_update,
  input  logic             is_jump,
  input  core_pkg::pc_t    jump_target,
  output core_pkg::pc_t    ibus_adr,
  output logic             ibus_cyc,
  output logic             ibus_stb,
  input  core_pkg::instr_t ibus_rdata,
  input  logic             ibus_ack,
  output core_pkg::instr_t instr,
  output core_pkg::pc_t    pc,
  output logic             fetch_done
);
  import core_pkg::*;

  pc_t  next_pc;
  logic bus_done;

  // Ack qualified by our own strobe ends the transfer
  assign bus_done = ibus_stb && ibus_ack;

  // Sequential or redirected
  assign next_pc = is_jump ? jump_target : pc + pc_t'(`CORE_PC_STEP);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= entry;
      ibus_cyc <= 1'b0;
      ibus_stb <= 1'b0;
    end else begin
      // cyc and stb always move together
      if (fetch_start) begin
        ibus_cyc <= 1'b1;
        ibus_stb <= 1'b1;
      end else if (bus_done) begin
        ibus_cyc <= 1'b0;
        ibus_stb <= 1'b0;
      end
      if (pc_update) begin
        pc <= next_pc;
      end
    end
  end

  // Address captured at request, instruction word at ack
  always_ff @(posedge clk) begin
    if (fetch_start) begin
      ibus_adr <= pc;
    end
    if (bus_done) begin
      instr <= ibus_rdata;
    end
  end

  // Instruction register is loaded on the edge closing this cycle
  assign fetch_done = bus_done;

  a_adr_stable_while_waiting: assert property (
    @(posedge clk) disable iff (reset) ibus_stb && !ibus_ack |=> $stable(ibus_adr)
  );

  a_stb_drops_after_ack: assert property (
    @(posedge clk) disable iff (reset) bus_done |=> !ibus_stb && !ibus_cyc
  );

endmodule

//--- rtl/stage_control.sv
`timescale 1ns/100ps

module stage_control (
  input  logic clk,
  input  logic reset,
  input  logic fetch_done,
  output logic fetch_start,
  output logic execute_en,
  output logic write_en,
  output logic pc_update,
  output logic retire_valid
);
  import core_pkg::*;

  core_state_t state;
  core_state_t next_state;

  // Set once the bus request for this instruction has gone out
  logic fetch_issued;

  always_comb begin
    next_state = state;
    case (state)
      ST_FETCH: begin
        if (fetch_done) begin
          next_state = ST_DECODE;
        end
      end
      ST_DECODE:    next_state = ST_EXECUTE;
      ST_EXECUTE:   next_state = ST_WRITEBACK;
      ST_WRITEBACK: next_state = ST_FETCH;
      default:      next_state = ST_FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_FETCH;
      fetch_issued <= 1'b0;
    end else begin
      state <= next_state;
      if (fetch_start) begin
        fetch_issued <= 1'b1;
      end else if (fetch_done) begin
        fetch_issued <= 1'b0;
      end
    end
  end

  // Single pulse on the first cycle of ST_FETCH
  assign fetch_start = (state == ST_FETCH) && !fetch_issued;

  // Operands settle during ST_DECODE, result is captured here
  assign execute_en = (state == ST_EXECUTE);

  // Register write, PC advance and retire share the write-back cycle
  assign write_en     = (state == ST_WRITEBACK);
  assign pc_update    = (state == ST_WRITEBACK);
  assign retire_valid = (state == ST_WRITEBACK);

  a_no_fetch_during_write: assert property (
    @(posedge clk) disable iff (reset) !(fetch_start && write_en)
  );

  // Fetcher completion only while a request is outstanding
  a_done_while_fetching: assert property (
    @(posedge clk) disable iff (reset) fetch_done |-> (state == ST_FETCH) && fetch_issued
  );

endmodule

//--- rtl/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

  // Register and ALU values
  typedef logic [`CORE_XLEN-1:0] xlen_t;

  // Byte address of an instruction
  typedef logic [`CORE_XLEN-1:0] pc_t;

  // Raw instruction word as fetched
  typedef logic [`CORE_ILEN-1:0] instr_t;

  // Register index
  typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;

  // ALU operation selected by the decoder
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,
    ALU_LINK
  } alu_op_t;

  // One pass through these per instruction
  typedef enum logic [1:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_WRITEBACK
  } core_state_t;

endpackage

//--- rtl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and instruction widths
`define CORE_XLEN       64
`define CORE_ILEN       32

// Register index width, 32 architectural registers
`define CORE_REG_ADDR_W 5

// Byte distance between sequential instructions
`define CORE_PC_STEP    4

// Major opcodes of the supported instructions
`define CORE_OPC_OP_IMM 7'b0010011
`define CORE_OPC_OP     7'b0110011
`define CORE_OPC_LUI    7'b0110111
`define CORE_OPC_JAL    7'b1101111

`endif
